/* hw/umi_merge_pkg.sv */
`default_nettype none

package umi_merge_pkg;

   // arbiter mode select, two bits wide
   typedef enum logic [1:0] {
      ARB_FIXED     = 2'd0, // fixed priority, lowest index wins
      ARB_RESERVED1 = 2'd1, // reserved, behaves as fixed
      ARB_THERMO    = 2'd2, // thermometer fairness
      ARB_RESERVED3 = 2'd3  // reserved, behaves as fixed
   } arb_mode_t;

   // defaults for the top level parameters
   localparam int DEF_N           = 4;  // number of sources

   localparam int DEF_DW          = 32; // packet width in bits

   // entries per ingress queue
   // also the credit count each source starts with
   localparam int DEF_DEPTH       = 4;

   // credits the egress holds toward the sink after reset
   localparam int DEF_OUT_CREDITS = 2;

endpackage

`default_nettype wire

/* hw/umi_priority.sv */
`default_nettype none

module umi_priority #(
   parameter int N = umi_merge_pkg::DEF_N // number of requesters
) (
   input  wire  [N-1:0] requests, // already masked requests
   output logic [N-1:0] grants    // at most one bit set
);

   // lower[i] set when any request below i is active
   logic [N-1:0] lower;

   always_comb
   begin
      lower[0] = 1'b0; // bit 0 never loses
      for (int i = 1; i < N; i++)
      begin
         lower[i] = lower[i-1] | requests[i-1]; // ripple up
      end
   end

   // lowest set request wins, nothing when idle
   assign grants = requests & ~lower;

endmodule

`default_nettype wire

/* hw/umi_arbiter.sv */
`default_nettype none

module umi_arbiter #(
   parameter int N = umi_merge_pkg::DEF_N // number of requesters
) (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire umi_merge_pkg::arb_mode_t mode, // fixed or thermometer
   input  wire  [N-1:0]             mask,     // 1 disables a request
   input  wire  [N-1:0]             requests, // raw requests
   output logic [N-1:0]             grants    // one-hot or zero
);

   import umi_merge_pkg::*;

   logic         collision;     // an enabled request lost this cycle
   logic [N-1:0] thermometer;   // grows on collisions in thermo mode
   logic [N-1:0] spec_requests; // requests after both masks

   // thermometer register
   // shifts in a one per collision, clears once lower bits are full
   if (N > 1)
   begin : g_thermo
      always_ff @(posedge clk or negedge nreset)
      begin
         if (!nreset)
            thermometer <= '0;
         else if (collision && (mode == ARB_THERMO))
         begin
            if (&thermometer[N-2:0])
               thermometer <= '0; // wrap back to all open
            else
               thermometer <= {thermometer[N-2:0], 1'b1};
         end
      end
   end
   else
   begin : g_no_thermo
      assign thermometer = '0; // single source needs no fairness
   end

   // per-source mask first, then thermometer
   assign spec_requests = requests & ~mask & ~thermometer;

   umi_priority #(
      .N (N)
   ) u_priority (
      .requests (spec_requests),
      .grants   (grants)
   );

   // masked sources are not counted as losers
   assign collision = |(requests & ~mask & ~grants);

   // grant is single, requested and not masked off by the source mask
   a_grant_legal: assert property (@(posedge clk) disable iff (!nreset)
      $onehot0(grants) && ((grants & (mask | ~requests)) == '0))
      else $error("umi_arbiter: illegal grant %b", grants);

endmodule

`default_nettype wire

/* hw/umi_ingress.sv */
`default_nettype none

module umi_ingress #(
   parameter int DW    = umi_merge_pkg::DEF_DW,   // packet width
   parameter int DEPTH = umi_merge_pkg::DEF_DEPTH // queue entries
) (
   input  wire           clk,
   input  wire           nreset,
   // source side
   input  wire           in_valid,  // push, only with a credit held
   input  wire  [DW-1:0] in_data,
   output logic          in_credit, // one pulse per popped entry
   // egress side
   input  wire           q_pop,     // remove head this cycle
   output logic          q_valid,   // queue not empty
   output logic [DW-1:0] q_data     // head entry
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // pointer width
   localparam int CW = $clog2(DEPTH + 1);               // count width

   logic [DW-1:0] mem [DEPTH]; // entry storage
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;       // entries held
   logic          full;
   logic          push;        // accepted write
   logic          pop;         // accepted read

   // pointer step with wrap, DEPTH need not be a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == CW'(DEPTH));
   assign q_valid = (count != '0);
   assign q_data  = mem[rd_ptr]; // head is visible combinationally

   assign push = in_valid & ~full; // full push is dropped, flagged below
   assign pop  = q_pop & q_valid;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_credit <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // idle or both at once
         endcase
         in_credit <= pop; // credit goes back the cycle after the pop
      end
   end

   // storage write
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   // source pushed without a credit
   a_push_full: assert property (@(posedge clk) disable iff (!nreset)
      in_valid |-> !full)
      else $error("umi_ingress: push into full queue, credit violation");

   // egress popped an empty queue
   a_pop_empty: assert property (@(posedge clk) disable iff (!nreset)
      q_pop |-> q_valid)
      else $error("umi_ingress: pop of empty queue");

endmodule

`default_nettype wire

/* hw/umi_egress.sv */
`default_nettype none

module umi_egress #(
   parameter int N           = umi_merge_pkg::DEF_N,
   parameter int DW          = umi_merge_pkg::DEF_DW,
   parameter int OUT_CREDITS = umi_merge_pkg::DEF_OUT_CREDITS,
   localparam int SW         = (N > 1) ? $clog2(N) : 1 // source index width
) (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire umi_merge_pkg::arb_mode_t mode,
   input  wire  [N-1:0]             mask,       // per-source disable
   // queue side
   input  wire  [N-1:0]             q_valid,
   input  wire  [N*DW-1:0]          q_data,     // heads, source 0 lowest
   output logic [N-1:0]             q_pop,      // one-hot or zero
   // sink side
   output logic                     out_valid,
   output logic [DW-1:0]            out_data,
   output logic [SW-1:0]            out_src,    // index of the source
   input  wire                      out_credit  // one pulse per packet consumed
);

   localparam int CW = $clog2(OUT_CREDITS + 1); // credit counter width

   logic [CW-1:0] credits;     // output credits held
   logic          have_credit;
   logic [N-1:0]  requests;    // queues that may compete
   logic [N-1:0]  grants;
   logic          send;        // a packet leaves this cycle
   logic [DW-1:0] sel_data;    // granted head
   logic [SW-1:0] sel_src;     // granted index

   assign have_credit = (credits != '0);
   assign requests    = q_valid & {N{have_credit}}; // no credit, no contest

   umi_arbiter #(
      .N (N)
   ) u_arbiter (
      .clk      (clk),
      .nreset   (nreset),
      .mode     (mode),
      .mask     (mask),
      .requests (requests),
      .grants   (grants)
   );

   assign q_pop = grants; // pop in the grant cycle
   assign send  = |grants;

   // one-hot select of the head and its encoded index
   always_comb
   begin
      sel_data = '0;
      sel_src  = '0;
      for (int i = 0; i < N; i++)
      begin
         if (grants[i])
         begin
            sel_data = q_data[i*DW +: DW];
            sel_src  = SW'(i);
         end
      end
   end

   // credit counter and output valid
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         credits   <= CW'(OUT_CREDITS);
         out_valid <= 1'b0;
      end
      else
      begin
         case ({send, out_credit})
            2'b10:   credits <= credits - 1'b1; // spent one
            2'b01:   credits <= credits + 1'b1; // sink returned one
            default: credits <= credits;        // none or both
         endcase
         out_valid <= send;
      end
   end

   // output payload
   always_ff @(posedge clk)
   begin
      if (send)
      begin
         out_data <= sel_data;
         out_src  <= sel_src;
      end
   end

   // sink must not return more credits than it was given
   a_credit_max: assert property (@(posedge clk) disable iff (!nreset)
      credits <= CW'(OUT_CREDITS))
      else $error("umi_egress: output credits above %0d", OUT_CREDITS);

endmodule

`default_nettype wire

/* hw/umi_merge.sv */
`default_nettype none

module umi_merge #(
   parameter int N           = umi_merge_pkg::DEF_N,          // sources
   parameter int DW          = umi_merge_pkg::DEF_DW,         // packet width
   parameter int DEPTH       = umi_merge_pkg::DEF_DEPTH,      // queue depth
   parameter int OUT_CREDITS = umi_merge_pkg::DEF_OUT_CREDITS,
   localparam int SW         = (N > 1) ? $clog2(N) : 1        // source index width
) (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire umi_merge_pkg::arb_mode_t mode,
   input  wire  [N-1:0]             mask,
   // sources, flattened with source 0 in the low bits
   input  wire  [N-1:0]             in_valid,
   input  wire  [N*DW-1:0]          in_data,
   output logic [N-1:0]             in_credit,
   // sink
   output logic                     out_valid,
   output logic [DW-1:0]            out_data,
   output logic [SW-1:0]            out_src,
   input  wire                      out_credit
);

   logic [N-1:0]    q_valid; // per queue not empty
   logic [N*DW-1:0] q_data;  // per queue head
   logic [N-1:0]    q_pop;   // from the egress grant

   // one queue per source
   for (genvar g = 0; g < N; g++)
   begin : g_ingress
      umi_ingress #(
         .DW    (DW),
         .DEPTH (DEPTH)
      ) u_ingress (
         .clk       (clk),
         .nreset    (nreset),
         .in_valid  (in_valid[g]),
         .in_data   (in_data[g*DW +: DW]),
         .in_credit (in_credit[g]),
         .q_pop     (q_pop[g]),
         .q_valid   (q_valid[g]),
         .q_data    (q_data[g*DW +: DW])
      );
   end

   // single drain point onto the output channel
   umi_egress #(
      .N           (N),
      .DW          (DW),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_egress (
      .clk        (clk),
      .nreset     (nreset),
      .mode       (mode),
      .mask       (mask),
      .q_valid    (q_valid),
      .q_data     (q_data),
      .q_pop      (q_pop),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_src    (out_src),
      .out_credit (out_credit)
   );

endmodule

`default_nettype wire

/* testbench/tb_umi_merge.sv */
`default_nettype none

module tb_umi_merge;
   timeunit 1ns;
   timeprecision 100ps;

   import umi_merge_pkg::*;

   localparam int N           = 4;
   localparam int DW          = 32;
   localparam int DEPTH       = 4;
   localparam int OUT_CREDITS = 2;
   localparam int SW          = 2;
   localparam int RAND_PKTS   = 400;
   localparam int TOTAL_PKTS  = 3 * N * DEPTH + RAND_PKTS; // three directed fills plus random
   localparam int CYCLE_LIMIT = 20 * TOTAL_PKTS + 200;

   logic            clk = 1'b0;
   logic            nreset;
   arb_mode_t       mode;
   logic [N-1:0]    mask;
   logic [N-1:0]    in_valid;
   logic [N*DW-1:0] in_data;
   logic [N-1:0]    in_credit;
   logic            out_valid;
   logic [DW-1:0]   out_data;
   logic [SW-1:0]   out_src;
   logic            out_credit;

   logic [DW-1:0] model_q [N][$]; // packets sent by each source
   int            src_credits [N];
   int            sink_credits;   // credits the egress may still spend
   int            errors = 0;
   int            pushes = 0;
   int            outputs = 0;
   int            cycles = 0;
   int            seq = 0;        // running sequence number
   integer        seed;
   logic [N-1:0]  therm;          // expected thermometer
   logic          check_prio;     // order checks only when no pushes race the grant

   umi_merge #(.N(N), .DW(DW), .DEPTH(DEPTH), .OUT_CREDITS(OUT_CREDITS)) DUT (
      .clk(clk), .nreset(nreset), .mode(mode), .mask(mask),
      .in_valid(in_valid), .in_data(in_data), .in_credit(in_credit),
      .out_valid(out_valid), .out_data(out_data), .out_src(out_src),
      .out_credit(out_credit)
   );

   always #50 clk = ~clk; // 100 ns period

   // watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, %0d of %0d packets out", cycles, outputs, pushes);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic int lowest(input logic [N-1:0] v);
      for (int i = 0; i < N; i++)
         if (v[i])
            return i;
      return -1; // nothing set
   endfunction

   // grows by one bit and clears once all lower bits are set
   function automatic logic [N-1:0] therm_step(input logic [N-1:0] t);
      if (&t[N-2:0])
         return '0;
      return {t[N-2:0], 1'b1};
   endfunction

   function automatic logic [N-1:0] pending(input logic [N-1:0] m);
      logic [N-1:0] v;
      for (int i = 0; i < N; i++)
         v[i] = (model_q[i].size() != 0) && !m[i];
      return v;
   endfunction

   task automatic check_output;
      logic [N-1:0]  busy;
      logic [DW-1:0] exp_data;
      int            exp_src;
      assert (sink_credits > 0)
      else
      begin
         errors++;
         $display("packet at %0t arrived while the sink held no credits", $time);
      end
      sink_credits--;
      outputs++;
      assert (!mask[out_src])
      else
      begin
         errors++;
         $display("packet at %0t came from masked source %0d", $time, out_src);
      end
      if (check_prio)
      begin
         busy = pending(mask); // queue contents at grant time
         if (mode == ARB_THERMO)
            for (int k = 0; k <= N && busy != '0 && (busy & ~therm) == '0; k++)
               therm = therm_step(therm); // blocked cycles still collide
         exp_src = lowest(busy & ~therm);
         assert (int'(out_src) == exp_src)
         else
         begin
            errors++;
            $display("mismatch at %0t: out_src expected %0d got %0d", $time, exp_src, out_src);
         end
         if (mode == ARB_THERMO && exp_src >= 0 && (busy & ~(N'(1) << exp_src)) != '0)
            therm = therm_step(therm);
      end
      if (model_q[out_src].size() == 0)
      begin
         errors++;
         $display("packet at %0t from source %0d that had nothing queued", $time, out_src);
      end
      else
      begin
         exp_data = model_q[out_src].pop_front();
         assert (out_data == exp_data)
         else
         begin
            errors++;
            $display("mismatch at %0t: out_data expected %h got %h", $time, exp_data, out_data);
         end
      end
   endtask

   // sample just after the edge then release the pulses
   task automatic step;
      @(posedge clk);
      #1;
      for (int i = 0; i < N; i++)
         if (in_credit[i])
            src_credits[i]++;
      if (out_valid)
         check_output();
      // every entry is either queued or back with its source as a credit
      for (int i = 0; i < N; i++)
         assert (src_credits[i] + model_q[i].size() == DEPTH)
         else
         begin
            errors++;
            $display("mismatch at %0t: in_credit[%0d] credits plus queued expected %0d got %0d",
                     $time, i, DEPTH, src_credits[i] + model_q[i].size());
         end
      in_valid   = '0;
      out_credit = 1'b0;
   endtask

   task automatic push(input int i);
      logic [31:0]   r;
      logic [DW-1:0] data;
      r = $random(seed);
      data = {4'(i), 12'(seq), r[15:0]}; // source tag, sequence, random
      in_valid[i] = 1'b1;
      in_data[i*DW +: DW] = data;
      model_q[i].push_back(data);
      src_credits[i]--;
      pushes++;
      seq++;
   endtask

   task automatic give_credit;
      out_credit = 1'b1;
      sink_credits++;
   endtask

   // DEPTH packets from every source while the sink withholds credits
   task automatic fill_queues;
      int left [N];
      for (int i = 0; i < N; i++)
         left[i] = DEPTH;
      while (left.sum() > 0)
      begin
         step();
         for (int i = 0; i < N; i++)
            if (left[i] > 0 && src_credits[i] > 0)
            begin
               push(i);
               left[i]--;
            end
      end
      while (sink_credits != 0)
         step(); // egress spends whatever it still held
      repeat (2) step();
   endtask

   // one credit per packet until the unmasked queues are empty
   task automatic drain_single;
      int target;
      check_prio = 1'b1;
      while (pending(mask) != '0)
      begin
         step();
         give_credit();
         target = outputs + 1;
         while (outputs < target)
            step();
      end
      check_prio = 1'b0;
   endtask

   initial
   begin
      int target;
      logic [31:0] r;
      seed = 32'h6029;
      nreset = 1'b0;
      mode = ARB_FIXED;
      mask = '0;
      in_valid = '0;
      in_data = '0;
      out_credit = 1'b0;
      therm = '0;
      check_prio = 1'b0;
      sink_credits = OUT_CREDITS;
      for (int i = 0; i < N; i++)
         src_credits[i] = DEPTH;
      repeat (3) @(posedge clk);
      #1 nreset = 1'b1;

      fill_queues(); // fixed priority
      drain_single();
      mask = 4'b0101; // fixed priority with sources 0 and 2 held
      fill_queues();
      drain_single();
      mask = '0;
      drain_single();
      mode = ARB_THERMO; // egress has no credits here, so no collisions yet
      fill_queues();
      drain_single();

      for (int p = 0; p < 4; p++)
      begin
         step();
         mode = (p % 2) ? ARB_THERMO : ARB_FIXED;
         r = $random(seed);
         mask = r[N-1:0] & ~(N'(1) << (N - 1)); // top source never thermometer-masked
         target = pushes + RAND_PKTS / 4;
         while (pushes < target)
         begin
            step();
            for (int i = 0; i < N; i++)
            begin
               r = $random(seed);
               if (pushes < target && src_credits[i] > 0 && r[0])
                  push(i);
            end
            r = $random(seed);
            if (sink_credits < OUT_CREDITS && r[1])
               give_credit();
         end
      end
      step();
      mask = '0;
      mode = ARB_THERMO; // wraps, so every queue drains
      while (outputs < pushes)
      begin
         step();
         if (sink_credits < OUT_CREDITS)
            give_credit();
      end
      repeat (4) step();

      for (int i = 0; i < N; i++)
         assert (model_q[i].size() == 0)
         else
         begin
            errors++;
            $display("source %0d still has %0d packets never seen", i, model_q[i].size());
         end
      assert (outputs == pushes)
      else
      begin
         errors++;
         $display("mismatch at %0t: output count expected %0d got %0d", $time, pushes, outputs);
      end
      $display("errors %0d, pushed %0d, output %0d, cycles %0d", errors, pushes, outputs, cycles);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
hw/umi_merge_pkg.sv
hw/umi_priority.sv
hw/umi_arbiter.sv
hw/umi_ingress.sv
hw/umi_egress.sv
hw/umi_merge.sv
testbench/tb_umi_merge.sv

/* run.sh */
#!/bin/sh
# build and run the merge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_umi_merge -f sources.f -Mdir obj_dir

./obj_dir/Vtb_umi_merge > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished cleanly"
